/* scope_capture.f */
+incdir+verilog
verilog/scope_pkg.sv
verilog/scope_control.sv
verilog/scope_timebase.sv
verilog/channel_sampler.sv
verilog/capture_buffer.sv
verilog/scope_capture.sv
sim/tb_scope_capture.sv

/* run_sim.sh */
#!/bin/sh
# Builds the scope capture testbench with Verilator and runs it.
# Any fail status line in the log marks the run as failed.

rm -rf obj_dir sim.log

verilator --binary --timing -Wno-fatal -f scope_capture.f \
    --top-module tb_scope_capture -o sim_scope_capture &&
./obj_dir/sim_scope_capture > sim.log 2>&1 || { echo "build or run error"; exit 1; }

cat sim.log
grep -q "STATUS: FAIL" sim.log && exit 1
grep -q "STATUS: PASS" sim.log || exit 1
exit 0

/* sim/tb_scope_capture.sv */
// ####################
// Testbench that applies a stimulus table to the scope capture DUT
// and checks it against a reference model
// ####################
`timescale 1ns/1ps
`include "scope_macros.svh"

module tb_scope_capture import scope_pkg::*; ();

    localparam int N = `SCOPE_N_CHANNELS;
    localparam int SAMPLES = `SCOPE_CHANNEL_SAMPLES;
    localparam int SEL_BASE = `SCOPE_REG_SELECTOR_BASE;
    localparam int CLK_PERIOD = 40;

    typedef enum logic [2:0] {
        OP_WRITE, OP_READ, OP_STREAM, OP_TICK, OP_IDLE, OP_BUFREAD, OP_WAIT_DONE
    } op_t;

    // arg is the address, tag, channel or idle length
    // data is the write word or the buffer index
    typedef struct packed {
        op_t op;
        int arg;
        reg_word_t data;
        reg_word_t expected;
    } step_rec_t;

    logic clock;
    logic rst;
    logic in_valid;
    dest_tag_t in_dest;
    stream_word_t in_data;
    logic ext_tick;
    logic reg_write;
    logic reg_read;
    logic [`SCOPE_REG_ADDR_WIDTH-1:0] reg_addr;
    reg_word_t reg_wdata;
    reg_word_t reg_rdata;
    buffer_addr_t buf_addr;
    sample_t buf_data;
    logic dma_done;

    step_rec_t steps[$];
    string labels[$];
    int seed;
    int errors;
    int checks;
    int current_test;
    int watchdog_cycles;
    logic table_ready;

    // Reference model state
    sample_t model_held [N];
    dest_tag_t model_sel [N];
    sample_t model_buf [SAMPLES][N];
    int model_index;
    logic model_disable;

    scope_capture i_scope_capture (
        .clock(clock),
        .rst(rst),
        .in_valid(in_valid),
        .in_dest(in_dest),
        .in_data(in_data),
        .ext_tick(ext_tick),
        .reg_write(reg_write),
        .reg_read(reg_read),
        .reg_addr(reg_addr),
        .reg_wdata(reg_wdata),
        .reg_rdata(reg_rdata),
        .buf_addr(buf_addr),
        .buf_data(buf_data),
        .dma_done(dma_done)
    );

    initial begin
        clock = 1'b0;
        forever #(CLK_PERIOD / 2) clock = ~clock;
    end

    // All DUT outputs are registered, so they are stable 2 ns after the edge
    task automatic step_cycle();
        @(posedge clock);
        #2;
    endtask

    task automatic check_word(input string name, input reg_word_t expected,
                              input reg_word_t actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("Error %s: expected 0x%h, got 0x%h", name, expected, actual);
        end
    endtask

    task automatic check_sample(input string name, input sample_t expected,
                                input sample_t actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("Error %s: expected 0x%h, got 0x%h", name, expected, actual);
        end
    endtask

    task automatic check_done(input logic expected, input logic actual, input int cycle);
        checks++;
        if (expected && actual !== 1'b1) begin
            errors++;
            $display("dma_done pulse missing in cycle %0d of test %0d", cycle, current_test);
        end else if (!expected && actual !== 1'b0) begin
            errors++;
            $display("Error dma_done: expected 0x0, got 0x%h in cycle %0d of test %0d",
                     actual, cycle, current_test);
        end
    endtask

    task automatic add_step(input string label, input op_t op, input int arg,
                            input reg_word_t data, input reg_word_t expected);
        step_rec_t rec;
        rec.op = op;
        rec.arg = arg;
        rec.data = data;
        rec.expected = expected;
        steps.push_back(rec);
        labels.push_back(label);
    endtask

    // Snapshot of all held channels goes to the current index, then fresh flags drop
    task automatic model_capture();
        for (int ch = 0; ch < N; ch++) begin
            model_buf[model_index][ch] = model_held[ch];
            model_held[ch].fresh = 1'b0;
        end
        model_index = (model_index + 1) % SAMPLES;
    endtask

    task automatic model_register_write(input int addr, input reg_word_t data);
        if (addr == `SCOPE_REG_CONTROL) begin
            model_disable = data[`SCOPE_CTRL_DISABLE_BIT];
            // A control write starts a new frame
            model_index = 0;
        end
        if (addr >= SEL_BASE && addr < SEL_BASE + N) begin
            model_sel[addr - SEL_BASE] = dest_tag_t'(data);
        end
    endtask

    task automatic build_table();
        add_step("status after reset", OP_READ, `SCOPE_REG_STATUS, 0, 32'h0);
        // Stop the divide-by-one captures that run right out of reset
        add_step("park capture", OP_WRITE, `SCOPE_REG_CONTROL, 32'h0100_0001, 0);
        add_step("settle", OP_IDLE, 2, 0, 0);
        add_step("write divider", OP_WRITE, `SCOPE_REG_DIVIDER, 32'h0000_1234, 0);
        add_step("read divider", OP_READ, `SCOPE_REG_DIVIDER, 0, 32'h0000_1234);
        for (int ch = 0; ch < N; ch++) begin
            add_step("write selector", OP_WRITE, SEL_BASE + ch, 32'h11 * (ch + 1), 0);
        end
        for (int ch = 0; ch < N; ch++) begin
            add_step("read selector", OP_READ, SEL_BASE + ch, 0, 32'h11 * (ch + 1));
        end
        add_step("external mode", OP_WRITE, `SCOPE_REG_CONTROL, 32'h0100_0000, 0);
        add_step("read control", OP_READ, `SCOPE_REG_CONTROL, 0, 32'h0100_0000);
        add_step("status after control", OP_READ, `SCOPE_REG_STATUS, 0, 32'h0);

        // Tag 0x55 matches no channel and channel 3 never sees its own tag
        add_step("stream tag 11", OP_STREAM, 8'h11, 0, 0);
        add_step("stream tag 22", OP_STREAM, 8'h22, 0, 0);
        add_step("stream tag 55", OP_STREAM, 8'h55, 0, 0);
        add_step("stream tag 11 again", OP_STREAM, 8'h11, 0, 0);
        add_step("stream tag 33", OP_STREAM, 8'h33, 0, 0);
        add_step("capture 0", OP_TICK, 0, 0, 0);
        add_step("stream tag 22 again", OP_STREAM, 8'h22, 0, 0);
        add_step("capture 1", OP_TICK, 0, 0, 0);
        // Two captures leave the index at 2 in bits 11:8 of the status word
        add_step("status mid frame", OP_READ, `SCOPE_REG_STATUS, 0, 32'h0000_0200);
        for (int ch = 0; ch < N; ch++) begin
            add_step("readout index 0", OP_BUFREAD, ch, 0, 0);
            add_step("readout index 1", OP_BUFREAD, ch, 1, 0);
        end

        // Sixteen external ticks fill a frame and only the last one ends it
        add_step("restart frame", OP_WRITE, `SCOPE_REG_CONTROL, 32'h0100_0000, 0);
        for (int i = 0; i < SAMPLES; i++) begin
            add_step("frame tick", OP_TICK, 0, 0, (i == SAMPLES - 1) ? 32'h1 : 32'h0);
        end
        add_step("status frame complete", OP_READ, `SCOPE_REG_STATUS, 0, 32'h0000_0001);
        add_step("readout last index", OP_BUFREAD, 1, SAMPLES - 1, 0);

        // Divider 3 ticks every 4 cycles. The mode change costs 2 cycles before
        // the count starts, then 16 periods, then the strobe and dma_done registers
        add_step("divider 3", OP_WRITE, `SCOPE_REG_DIVIDER, 32'h3, 0);
        add_step("internal mode", OP_WRITE, `SCOPE_REG_CONTROL, 32'h0, 0);
        add_step("divider frame", OP_WAIT_DONE, 0, 0, 2 + SAMPLES * (3 + 1) + 2);

        add_step("disable capture", OP_WRITE, `SCOPE_REG_CONTROL, 32'h0100_0001, 0);
        add_step("status when disabled", OP_READ, `SCOPE_REG_STATUS, 0, 32'h0);
        add_step("stream while disabled", OP_STREAM, 8'h11, 0, 0);
        add_step("stream while disabled", OP_STREAM, 8'h22, 0, 0);
        add_step("stream while disabled", OP_STREAM, 8'h33, 0, 0);
        for (int i = 0; i < SAMPLES; i++) begin
            add_step("disabled tick", OP_TICK, 0, 0, 32'h0);
        end
        add_step("readout kept 0", OP_BUFREAD, 0, 0, 0);
        add_step("readout kept 7", OP_BUFREAD, 1, 7, 0);
        add_step("readout kept 15", OP_BUFREAD, 2, SAMPLES - 1, 0);
        add_step("index held", OP_READ, `SCOPE_REG_STATUS, 0, 32'h0);
    endtask

    task automatic apply_step(input step_rec_t rec);
        stream_word_t word;
        int cyc;
        case (rec.op)
            OP_WRITE: begin
                reg_write = 1'b1;
                reg_addr = `SCOPE_REG_ADDR_WIDTH'(rec.arg);
                reg_wdata = rec.data;
                step_cycle();
                reg_write = 1'b0;
                model_register_write(rec.arg, rec.data);
            end
            OP_READ: begin
                reg_read = 1'b1;
                reg_addr = `SCOPE_REG_ADDR_WIDTH'(rec.arg);
                step_cycle();
                reg_read = 1'b0;
                check_word("reg_rdata", rec.expected, reg_rdata);
            end
            OP_STREAM: begin
                word = $random(seed);
                in_valid = 1'b1;
                in_dest = dest_tag_t'(rec.arg);
                in_data = word;
                step_cycle();
                in_valid = 1'b0;
                for (int ch = 0; ch < N; ch++) begin
                    if (model_sel[ch] == dest_tag_t'(rec.arg)) begin
                        model_held[ch].data = word;
                        model_held[ch].fresh = 1'b1;
                    end
                end
            end
            OP_TICK: begin
                // Tick, then sample_tick, then the strobe, then dma_done
                ext_tick = 1'b1;
                step_cycle();
                ext_tick = 1'b0;
                check_done(1'b0, dma_done, 1);
                step_cycle();
                check_done(1'b0, dma_done, 2);
                step_cycle();
                if (!model_disable) begin
                    model_capture();
                end
                check_done(rec.expected[0], dma_done, 3);
            end
            OP_IDLE: begin
                repeat (rec.arg) step_cycle();
            end
            OP_BUFREAD: begin
                buf_addr.channel = `SCOPE_CHANNEL_WIDTH'(rec.arg);
                buf_addr.index = sample_index_t'(rec.data);
                step_cycle();
                check_sample("buf_data", model_buf[int'(rec.data)][rec.arg], buf_data);
            end
            OP_WAIT_DONE: begin
                // The control write just before left us one cycle in
                // One cycle past the pulse is watched so the pulse must end
                cyc = 1;
                while (cyc <= int'(rec.expected)) begin
                    step_cycle();
                    cyc++;
                    check_done(cyc == int'(rec.expected), dma_done, cyc);
                end
                repeat (SAMPLES) model_capture();
            end
            default: begin
                errors++;
                $display("Test %0d has an unknown operation", current_test);
            end
        endcase
    endtask

    initial begin
        int first_errors;
        seed = 32'hd4e3;
        errors = 0;
        checks = 0;
        current_test = 0;
        table_ready = 1'b0;
        rst = 1'b1;
        in_valid = 1'b0;
        in_dest = '0;
        in_data = '0;
        ext_tick = 1'b0;
        reg_write = 1'b0;
        reg_read = 1'b0;
        reg_addr = '0;
        reg_wdata = '0;
        buf_addr = '0;
        model_index = 0;
        model_disable = 1'b0;
        for (int ch = 0; ch < N; ch++) begin
            model_held[ch] = '0;
            model_sel[ch] = '0;
        end

        build_table();
        // Reset cycles plus the cycles of every step, with some slack on top
        watchdog_cycles = 5 + 100;
        foreach (steps[i]) begin
            case (steps[i].op)
                OP_TICK: watchdog_cycles += 4;
                OP_IDLE: watchdog_cycles += steps[i].arg;
                OP_WAIT_DONE: watchdog_cycles += int'(steps[i].expected) + 1;
                default: watchdog_cycles += 1;
            endcase
        end
        table_ready = 1'b1;

        repeat (5) step_cycle();
        rst = 1'b0;

        foreach (steps[i]) begin
            current_test = i;
            first_errors = errors;
            apply_step(steps[i]);
            $display("test %0d %s: %s", i, labels[i],
                     (errors == first_errors) ? "ok" : "failed");
        end

        $display("%0d tests, %0d checks, %0d errors", steps.size(), checks, errors);
        if (errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

    // Ends a run that hangs after a budget worked out from the stimulus table
    initial begin
        wait (table_ready);
        #(watchdog_cycles * CLK_PERIOD);
        $display("Timeout: run did not finish within %0d clock cycles", watchdog_cycles);
        $display("STATUS: FAIL");
        $finish;
    end

endmodule

/* verilog/scope_capture.sv */
// ####################
// Scope capture top: control, timebase, channel samplers and frame buffer
// ####################
`timescale 1ns/1ps
`include "scope_macros.svh"

module scope_capture import scope_pkg::*; (
    input  logic clock,
    input  logic rst,
    input  logic in_valid,
    input  dest_tag_t in_dest,
    input  stream_word_t in_data,
    input  logic ext_tick,
    input  logic reg_write,
    input  logic reg_read,
    input  logic [`SCOPE_REG_ADDR_WIDTH-1:0] reg_addr,
    input  reg_word_t reg_wdata,
    output reg_word_t reg_rdata,
    input  buffer_addr_t buf_addr,
    output sample_t buf_data,
    output logic dma_done
);

    logic [`SCOPE_DIV_WIDTH-1:0] divider;
    logic external_timebase;
    dest_tag_t [`SCOPE_N_CHANNELS-1:0] selector;
    logic sample_tick;
    logic capture_strobe;
    sample_index_t write_index;
    sample_t [`SCOPE_N_CHANNELS-1:0] held_samples;

    // Register file and capture sequencing
    scope_control i_control (
        .clock(clock),
        .rst(rst),
        .reg_write(reg_write),
        .reg_read(reg_read),
        .reg_addr(reg_addr),
        .reg_wdata(reg_wdata),
        .sample_tick(sample_tick),
        .reg_rdata(reg_rdata),
        .divider(divider),
        .external_timebase(external_timebase),
        .selector(selector),
        .capture_strobe(capture_strobe),
        .write_index(write_index),
        .dma_done(dma_done)
    );

    scope_timebase i_timebase (
        .clock(clock),
        .rst(rst),
        .divider(divider),
        .external_timebase(external_timebase),
        .ext_tick(ext_tick),
        .sample_tick(sample_tick)
    );

    // Every sampler watches the same stream and picks its own tag
    for (genvar ch = 0; ch < `SCOPE_N_CHANNELS; ch++) begin : g_channel
        channel_sampler i_sampler (
            .clock(clock),
            .rst(rst),
            .selector(selector[ch]),
            .in_valid(in_valid),
            .in_dest(in_dest),
            .in_data(in_data),
            .capture_strobe(capture_strobe),
            .held(held_samples[ch])
        );
    end

    capture_buffer i_buffer (
        .clock(clock),
        .capture_strobe(capture_strobe),
        .write_index(write_index),
        .samples(held_samples),
        .buf_addr(buf_addr),
        .buf_data(buf_data)
    );

endmodule

/* verilog/capture_buffer.sv */
// ####################
// Capture buffer: frame memory of all channel snapshots with a read port
// ####################
`timescale 1ns/1ps
`include "scope_macros.svh"

module capture_buffer import scope_pkg::*; (
    input  logic clock,
    input  logic capture_strobe,
    input  sample_index_t write_index,
    input  sample_t [`SCOPE_N_CHANNELS-1:0] samples,
    input  buffer_addr_t buf_addr,
    output sample_t buf_data
);

    // One row per sample index, each row holding every channel side by side,
    // so a capture is a single row write
    sample_t [`SCOPE_N_CHANNELS-1:0] frame_mem [`SCOPE_CHANNEL_SAMPLES];

    // The whole snapshot goes in at the edge that closes the strobe cycle
    always_ff @(posedge clock) begin
        if (capture_strobe) begin
            frame_mem[write_index] <= samples;
        end
    end

    // Registered readout, independent of the write side
    // A read of the row being written in the same cycle returns the old contents
    always_ff @(posedge clock) begin
        buf_data <= frame_mem[buf_addr.index][buf_addr.channel];
    end

endmodule

/* verilog/channel_sampler.sv */
// ####################
// Channel sampler: keeps the latest stream word matching its tag selector
// ####################
`timescale 1ns/1ps

module channel_sampler import scope_pkg::*; (
    input  logic clock,
    input  logic rst,
    input  dest_tag_t selector,
    input  logic in_valid,
    input  dest_tag_t in_dest,
    input  stream_word_t in_data,
    input  logic capture_strobe,
    output sample_t held
);

    logic tag_match;

    // The stream never stalls, so every valid word is looked at exactly once
    assign tag_match = in_valid && (in_dest == selector);

    // A matching word is visible on held from the next cycle on
    // The buffer samples held at the end of the strobe cycle, so a word that
    // lands together with the strobe misses this capture and waits for the next
    always_ff @(posedge clock) begin
        if (rst) begin
            held <= '0;
        end else if (tag_match) begin
            held.data <= in_data;
            // New data wins over the strobe clearing the flag
            held.fresh <= 1'b1;
        end else if (capture_strobe) begin
            // The current value has been captured, later captures see it as stale
            held.fresh <= 1'b0;
        end
    end

endmodule

/* verilog/scope_timebase.sv */
// ####################
// Sample timebase: clock divider or external tick pass-through
// ####################
`timescale 1ns/1ps
`include "scope_macros.svh"

module scope_timebase (
    input  logic clock,
    input  logic rst,
    input  logic [`SCOPE_DIV_WIDTH-1:0] divider,
    input  logic external_timebase,
    input  logic ext_tick,
    output logic sample_tick
);

    logic [`SCOPE_DIV_WIDTH-1:0] count;
    logic mode_q;
    logic count_wrap;

    // Greater-or-equal so a divider lowered below the running count
    // wraps at once instead of running through the whole counter range
    assign count_wrap = (count >= divider);

    // Divider mode ticks once every divider+1 cycles, so a divider of zero
    // ticks on every cycle
    // External mode just registers the incoming tick
    always_ff @(posedge clock) begin
        if (rst) begin
            count <= '0;
            mode_q <= 1'b0;
            sample_tick <= 1'b0;
        end else begin
            mode_q <= external_timebase;
            if (external_timebase) begin
                // Counter parked at zero while the external tick is in use
                sample_tick <= ext_tick;
                count <= '0;
            end else if (external_timebase != mode_q) begin
                // First cycle back in divider mode restarts the count
                sample_tick <= 1'b0;
                count <= '0;
            end else begin
                sample_tick <= count_wrap;
                count <= count_wrap ? '0 : count + 1'b1;
            end
        end
    end

endmodule

/* verilog/scope_control.sv */
// ####################
// Scope control: register file, capture gating, frame index and dma_done
// ####################
`timescale 1ns/1ps
`include "scope_macros.svh"

module scope_control import scope_pkg::*; (
    input  logic clock,
    input  logic rst,
    input  logic reg_write,
    input  logic reg_read,
    input  logic [`SCOPE_REG_ADDR_WIDTH-1:0] reg_addr,
    input  reg_word_t reg_wdata,
    input  logic sample_tick,
    output reg_word_t reg_rdata,
    output logic [`SCOPE_DIV_WIDTH-1:0] divider,
    output logic external_timebase,
    output dest_tag_t [`SCOPE_N_CHANNELS-1:0] selector,
    output logic capture_strobe,
    output sample_index_t write_index,
    output logic dma_done
);

    localparam logic [`SCOPE_REG_ADDR_WIDTH-1:0] ADDR_CONTROL = `SCOPE_REG_CONTROL;
    localparam logic [`SCOPE_REG_ADDR_WIDTH-1:0] ADDR_DIVIDER = `SCOPE_REG_DIVIDER;
    localparam logic [`SCOPE_REG_ADDR_WIDTH-1:0] ADDR_SEL_BASE = `SCOPE_REG_SELECTOR_BASE;
    localparam logic [`SCOPE_REG_ADDR_WIDTH-1:0] ADDR_STATUS = `SCOPE_REG_STATUS;
    localparam sample_index_t LAST_INDEX = sample_index_t'(`SCOPE_CHANNEL_SAMPLES - 1);

    reg_word_t control_reg;
    reg_word_t status_word;
    reg_word_t read_word;
    logic disable_capture;
    logic frame_complete;
    logic control_write;
    logic last_sample;

    // Control word fields, the remaining bits are only stored for readback
    assign disable_capture = control_reg[`SCOPE_CTRL_DISABLE_BIT];
    assign external_timebase = control_reg[`SCOPE_CTRL_EXT_TB_BIT];

    assign control_write = reg_write && (reg_addr == ADDR_CONTROL);
    assign last_sample = capture_strobe && (write_index == LAST_INDEX);

    // Host writes to the control, divider and selector registers
    always_ff @(posedge clock) begin
        if (rst) begin
            control_reg <= '0;
            divider <= '0;
            selector <= '0;
        end else if (reg_write) begin
            if (reg_addr == ADDR_CONTROL) begin
                control_reg <= reg_wdata;
            end
            if (reg_addr == ADDR_DIVIDER) begin
                divider <= reg_wdata[`SCOPE_DIV_WIDTH-1:0];
            end
            // Each channel owns one address above the selector base
            for (int ch = 0; ch < `SCOPE_N_CHANNELS; ch++) begin
                if (reg_addr == ADDR_SEL_BASE + `SCOPE_REG_ADDR_WIDTH'(ch)) begin
                    selector[ch] <= reg_wdata[`SCOPE_DEST_WIDTH-1:0];
                end
            end
        end
    end

    // Status word: sticky frame flag in the low bit, current index above it
    always_comb begin
        status_word = '0;
        status_word[`SCOPE_STATUS_DONE_BIT] = frame_complete;
        status_word[`SCOPE_STATUS_INDEX_LSB +: `SCOPE_INDEX_WIDTH] = write_index;
    end

    // Readback mux, unmapped addresses return zero
    always_comb begin
        read_word = '0;
        case (reg_addr)
            ADDR_CONTROL: read_word = control_reg;
            ADDR_DIVIDER: read_word = reg_word_t'(divider);
            ADDR_STATUS: read_word = status_word;
            default: begin
                for (int ch = 0; ch < `SCOPE_N_CHANNELS; ch++) begin
                    if (reg_addr == ADDR_SEL_BASE + `SCOPE_REG_ADDR_WIDTH'(ch)) begin
                        read_word = reg_word_t'(selector[ch]);
                    end
                end
            end
        endcase
    end

    // Read data appears one cycle after the read request and then holds
    always_ff @(posedge clock) begin
        if (rst) begin
            reg_rdata <= '0;
        end else if (reg_read) begin
            reg_rdata <= read_word;
        end
    end

    // A tick becomes a capture strobe one cycle later unless capture is disabled
    // The strobe cycle writes the buffer at the current index, which then advances
    always_ff @(posedge clock) begin
        if (rst) begin
            capture_strobe <= 1'b0;
            write_index <= '0;
            dma_done <= 1'b0;
            frame_complete <= 1'b0;
        end else begin
            capture_strobe <= sample_tick && !disable_capture;
            dma_done <= last_sample;
            if (control_write) begin
                // Reprogramming the scope starts a new frame
                write_index <= '0;
                frame_complete <= 1'b0;
            end else if (capture_strobe) begin
                write_index <= last_sample ? '0 : write_index + 1'b1;
                if (last_sample) begin
                    frame_complete <= 1'b1;
                end
            end
        end
    end

endmodule

/* verilog/scope_pkg.sv */
// ####################
// Shared types of the scope capture block
// ####################
`include "scope_macros.svh"

package scope_pkg;

    // One word of the tagged input stream
    typedef logic [`SCOPE_DATA_WIDTH-1:0] stream_word_t;

    // Destination tag carried next to every stream word
    typedef logic [`SCOPE_DEST_WIDTH-1:0] dest_tag_t;

    // Held channel value as stored in the frame memory
    // The fresh flag tells whether the word arrived since the previous capture
    typedef struct packed {
        logic fresh;
        stream_word_t data;
    } sample_t;

    // Position of a sample inside one frame
    typedef logic [`SCOPE_INDEX_WIDTH-1:0] sample_index_t;

    // Register bus word
    typedef logic [31:0] reg_word_t;

    // Readout address of the frame memory, channel in the upper bits
    typedef struct packed {
        logic [`SCOPE_CHANNEL_WIDTH-1:0] channel;
        sample_index_t index;
    } buffer_addr_t;

endpackage

/* verilog/scope_macros.svh */
// ####################
// Scope capture constants: sizes, widths and register map
// ####################
`ifndef SCOPE_MACROS_SVH
`define SCOPE_MACROS_SVH

// Frame geometry
`define SCOPE_N_CHANNELS 4
`define SCOPE_CHANNEL_SAMPLES 16

// Stream and bus widths
`define SCOPE_DATA_WIDTH 32
`define SCOPE_DEST_WIDTH 8
`define SCOPE_DIV_WIDTH 16
`define SCOPE_REG_ADDR_WIDTH 4
`define SCOPE_INDEX_WIDTH ($clog2(`SCOPE_CHANNEL_SAMPLES))
`define SCOPE_CHANNEL_WIDTH ($clog2(`SCOPE_N_CHANNELS))

// Register addresses, selectors take one address per channel from the base
`define SCOPE_REG_CONTROL 0
`define SCOPE_REG_DIVIDER 1
`define SCOPE_REG_SELECTOR_BASE 2
`define SCOPE_REG_STATUS 6

// Field positions inside the control and status words
`define SCOPE_CTRL_DISABLE_BIT 0
`define SCOPE_CTRL_EXT_TB_BIT 24
`define SCOPE_STATUS_DONE_BIT 0
`define SCOPE_STATUS_INDEX_LSB 8

`endif
